/* hw/smpc_bus_regs.sv */
`timescale 1ns/1ns
module smpc_bus_regs (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic [5:0]           a,
	input  smpc_pkg::byte_t      di,
	input  logic                 cs_n,
	input  logic                 rw_n,
	input  logic                 sf_clear,
	input  smpc_pkg::byte_t      sr,
	input  smpc_pkg::byte_t      oreg_q,
	output smpc_pkg::byte_t      do_data,
	output logic                 cmd_valid,
	output smpc_pkg::byte_t      cmd_byte,
	output smpc_pkg::byte_t      ireg0,
	output smpc_pkg::byte_t      ireg1,
	output smpc_pkg::byte_t      ireg2,
	output smpc_pkg::byte_t      ireg3,
	output smpc_pkg::byte_t      ireg4,
	output smpc_pkg::byte_t      ireg5,
	output smpc_pkg::byte_t      ireg6,
	output smpc_pkg::oreg_addr_t oreg_raddr
);
	import smpc_pkg::*;

	logic [5:0] a_s;
	byte_t      di_s;
	logic       cs_n_s;
	logic       cs_n_d;
	logic       rw_n_s;
	logic       rw_n_d;
	logic       wr_edge;
	logic       rd_edge;
	reg_addr_t  addr;
	logic [5:0] oreg_off;
	byte_t      io_buf;     // Last byte written by the host
	logic       sf;

	assign addr       = {a_s, 1'b1};
	assign wr_edge    = !rw_n_s && rw_n_d && !cs_n_s;
	assign rd_edge    = !cs_n_s && cs_n_d && rw_n_s;
	assign oreg_off   = a_s - 6'h10;     // OREG0 sits at 0x21
	assign oreg_raddr = oreg_off[4:0];

	always_ff @(posedge CLK) begin
		a_s  <= a;
		di_s <= di;
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			cs_n_s    <= 1'b1;
			cs_n_d    <= 1'b1;
			rw_n_s    <= 1'b1;
			rw_n_d    <= 1'b1;
			cmd_valid <= 1'b0;
			cmd_byte  <= '0;
			ireg0     <= '0;
			ireg1     <= '0;
			ireg2     <= '0;
			ireg3     <= '0;
			ireg4     <= '0;
			ireg5     <= '0;
			ireg6     <= '0;
			io_buf    <= '0;
			sf        <= 1'b0;
			do_data   <= '0;
		end else begin
			cs_n_s    <= cs_n;
			cs_n_d    <= cs_n_s;
			rw_n_s    <= rw_n;
			rw_n_d    <= rw_n_s;
			cmd_valid <= 1'b0;
			if (sf_clear)
				sf <= 1'b0;
			if (wr_edge) begin
				io_buf <= di_s;
				case (addr)
					ADDR_IREG0: ireg0 <= di_s;
					ADDR_IREG1: ireg1 <= di_s;
					ADDR_IREG2: ireg2 <= di_s;
					ADDR_IREG3: ireg3 <= di_s;
					ADDR_IREG4: ireg4 <= di_s;
					ADDR_IREG5: ireg5 <= di_s;
					ADDR_IREG6: ireg6 <= di_s;
					ADDR_COMREG: begin
						cmd_byte  <= di_s;   // Overwrites a pending command
						cmd_valid <= 1'b1;
					end
					ADDR_SF: sf <= 1'b1;
					default: ;
				endcase
			end
			if (rd_edge) begin
				if (addr >= ADDR_OREG_FIRST && addr <= ADDR_OREG_LAST)
					do_data <= oreg_q;
				else begin
					case (addr)
						ADDR_SR: do_data <= sr;
						ADDR_SF: do_data <= {io_buf[7:1], sf};
						default: do_data <= io_buf;
					endcase
				end
			end
		end
	end

endmodule

/* hw/smpc_cmd_seq.sv */
`timescale 1ns/1ns
module smpc_cmd_seq (
	input  logic                 CLK,
	input  logic                 RST_N,
	input  logic                 cmd_valid,
	input  smpc_pkg::byte_t      cmd_byte,
	input  smpc_pkg::byte_t      ireg0,
	input  smpc_pkg::byte_t      ireg1,
	input  smpc_pkg::byte_t      ireg2,
	input  smpc_pkg::byte_t      ireg3,
	input  smpc_pkg::byte_t      ireg4,
	input  smpc_pkg::byte_t      ireg5,
	input  smpc_pkg::byte_t      ireg6,
	input  smpc_pkg::byte_t      year_hi,
	input  smpc_pkg::byte_t      year_lo,
	input  smpc_pkg::byte_t      month,
	input  smpc_pkg::byte_t      days,
	input  smpc_pkg::byte_t      hour,
	input  smpc_pkg::byte_t      min,
	input  smpc_pkg::byte_t      sec,
	output logic                 sf_clear,
	output smpc_pkg::byte_t      sr,
	output logic                 oreg_we,
	output smpc_pkg::oreg_addr_t oreg_wa,
	output smpc_pkg::byte_t      oreg_wd,
	output logic                 time_load,
	output logic                 SSHRES_N,
	output logic                 SNDRES_N,
	output logic                 CDRES_N,
	output logic                 MIRQ_N
);
	import smpc_pkg::*;

	cmd_state_t state;
	cmd_state_t ret_state;     // Where WAIT goes when the count runs out
	byte_t      command;
	logic [7:0] wait_cnt;
	logic [3:0] stat_idx;
	logic       pending;
	logic       resd;
	logic       ste;
	byte_t      stat_byte;
	logic       time_ok;

	function automatic logic bcd_ok(input byte_t v);
		return (v[7:4] <= 4'd9) && (v[3:0] <= 4'd9);
	endfunction

	// SETTIME is ignored unless every field is a legal BCD value
	assign time_ok = bcd_ok(ireg0) && bcd_ok(ireg1) && bcd_ok(ireg3) && bcd_ok(ireg4) &&
		bcd_ok(ireg5) && bcd_ok(ireg6) && ireg2[3:0] != 4'd0 && ireg2[3:0] <= 4'd12;

	always_comb begin
		case (stat_idx[2:0])
			3'd0: stat_byte = {ste, resd, 6'b000000};
			3'd1: stat_byte = year_hi;
			3'd2: stat_byte = year_lo;
			3'd3: stat_byte = month;
			3'd4: stat_byte = days;
			3'd5: stat_byte = hour;
			3'd6: stat_byte = min;
			default: stat_byte = sec;
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			state     <= IDLE;
			ret_state <= IDLE;
			command   <= '0;
			wait_cnt  <= '0;
			stat_idx  <= '0;
			pending   <= 1'b0;
			resd      <= 1'b1;
			ste       <= 1'b0;
			sr        <= '0;
			sf_clear  <= 1'b0;
			oreg_we   <= 1'b0;
			oreg_wa   <= '0;
			oreg_wd   <= '0;
			time_load <= 1'b0;
			SSHRES_N  <= 1'b0;
			SNDRES_N  <= 1'b0;
			CDRES_N   <= 1'b1;
			MIRQ_N    <= 1'b1;
		end else begin
			sf_clear  <= 1'b0;
			oreg_we   <= 1'b0;
			time_load <= 1'b0;
			MIRQ_N    <= 1'b1;
			case (state)
				IDLE: begin
					if (pending) begin
						pending   <= 1'b0;
						command   <= cmd_byte;
						wait_cnt  <= (cmd_byte[7:5] == 3'b000) ? WAIT_DECODE : WAIT_UNKNOWN;
						ret_state <= (cmd_byte[7:5] == 3'b000) ? CMD_HNIB : CMD_UNKNOWN;
						state     <= WAIT;
					end
				end
				WAIT: begin
					if (wait_cnt == 8'd0)
						state <= ret_state;
					else
						wait_cnt <= wait_cnt - 8'd1;
				end
				CMD_HNIB: begin
					oreg_we   <= 1'b1;
					oreg_wa   <= OREG_CMD_ECHO;
					oreg_wd   <= {command[7:4], 4'h0};
					wait_cnt  <= WAIT_NIBBLE;
					ret_state <= CMD_LNIB;
					state     <= WAIT;
				end
				CMD_LNIB: begin
					oreg_we <= 1'b1;
					oreg_wa <= OREG_CMD_ECHO;
					oreg_wd <= command;
					if (command == CMD_INTBACK) begin
						wait_cnt <= STAT_STEP;
						stat_idx <= '0;
						state    <= ireg0[0] ? INTBACK_STAT : END;
					end else begin
						wait_cnt  <= WAIT_EXEC;
						ret_state <= EXEC;
						state     <= WAIT;
					end
				end
				CMD_UNKNOWN: state <= END;
				INTBACK_STAT: begin
					if (wait_cnt != 8'd0)
						wait_cnt <= wait_cnt - 8'd1;
					else begin
						wait_cnt <= STAT_STEP;
						stat_idx <= stat_idx + 4'd1;
						if (stat_idx < 4'd8) begin
							oreg_we <= 1'b1;     // OREG0 status, OREG1-7 calendar
							oreg_wa <= {2'b00, stat_idx[2:0]};
							oreg_wd <= stat_byte;
						end else if (stat_idx == 4'd8)
							sr <= SR_STATUS;
						else begin
							MIRQ_N <= 1'b0;
							state  <= END;
						end
					end
				end
				EXEC: begin
					case (command)
						CMD_SSHON:  SSHRES_N <= 1'b1;
						CMD_SSHOFF: SSHRES_N <= 1'b0;
						CMD_SNDON:  SNDRES_N <= 1'b1;
						CMD_SNDOFF: SNDRES_N <= 1'b0;
						CMD_CDON:   CDRES_N  <= 1'b1;
						CMD_CDOFF:  CDRES_N  <= 1'b0;
						CMD_SETTIME: begin
							if (time_ok) begin
								ste       <= 1'b1;
								time_load <= 1'b1;
							end
						end
						CMD_RESENAB: resd <= 1'b0;
						CMD_RESDISA: resd <= 1'b1;
						default: ;
					endcase
					state <= END;
				end
				END: begin
					sf_clear <= 1'b1;
					state    <= IDLE;
				end
				default: state <= IDLE;
			endcase
			if (cmd_valid)
				pending <= 1'b1;     // Taken at the next IDLE
		end
	end

endmodule

/* hw/smpc_oreg_ram.sv */
`timescale 1ns/1ns
module smpc_oreg_ram (
	input  logic                 CLK,
	input  logic                 we,
	input  smpc_pkg::oreg_addr_t wa,
	input  smpc_pkg::byte_t      wd,
	input  smpc_pkg::oreg_addr_t ra,
	output smpc_pkg::byte_t      q
);
	import smpc_pkg::*;

	byte_t mem [32];

	always_ff @(posedge CLK) begin
		if (we)
			mem[wa] <= wd;
	end

	assign q = mem[ra];     // Host read path is combinational

endmodule

/* hw/smpc_pkg.sv */
package smpc_pkg;

	typedef logic [7:0] byte_t;
	typedef logic [6:0] reg_addr_t;      // {A[6:1], 1'b1}
	typedef logic [4:0] oreg_addr_t;

	typedef enum logic [2:0] {
		IDLE,
		WAIT,
		CMD_HNIB,
		CMD_LNIB,
		CMD_UNKNOWN,
		INTBACK_STAT,
		EXEC,
		END
	} cmd_state_t;

	// Host register map
	localparam reg_addr_t ADDR_IREG0      = 7'h01;
	localparam reg_addr_t ADDR_IREG1      = 7'h03;
	localparam reg_addr_t ADDR_IREG2      = 7'h05;
	localparam reg_addr_t ADDR_IREG3      = 7'h07;
	localparam reg_addr_t ADDR_IREG4      = 7'h09;
	localparam reg_addr_t ADDR_IREG5      = 7'h0B;
	localparam reg_addr_t ADDR_IREG6      = 7'h0D;
	localparam reg_addr_t ADDR_COMREG     = 7'h1F;
	localparam reg_addr_t ADDR_OREG_FIRST = 7'h21;
	localparam reg_addr_t ADDR_OREG_LAST  = 7'h5F;
	localparam reg_addr_t ADDR_SR         = 7'h61;
	localparam reg_addr_t ADDR_SF         = 7'h63;

	localparam byte_t CMD_SSHON   = 8'h02;
	localparam byte_t CMD_SSHOFF  = 8'h03;
	localparam byte_t CMD_SNDON   = 8'h06;
	localparam byte_t CMD_SNDOFF  = 8'h07;
	localparam byte_t CMD_CDON    = 8'h08;
	localparam byte_t CMD_CDOFF   = 8'h09;
	localparam byte_t CMD_INTBACK = 8'h10;
	localparam byte_t CMD_SETTIME = 8'h16;
	localparam byte_t CMD_RESENAB = 8'h19;
	localparam byte_t CMD_RESDISA = 8'h1A;

	localparam oreg_addr_t OREG_CMD_ECHO = 5'd31;

	// Sequencer wait times in clock cycles, scaled down
	localparam logic [7:0] WAIT_DECODE  = 8'd20;
	localparam logic [7:0] WAIT_NIBBLE  = 8'd6;
	localparam logic [7:0] WAIT_EXEC    = 8'd10;
	localparam logic [7:0] WAIT_UNKNOWN = 8'd24;
	localparam logic [7:0] STAT_STEP    = 8'd12;    // Gap between status bytes

	localparam int RTC_TICK_CYCLES = 2000;       // One calendar second

	localparam byte_t SR_STATUS = 8'h4F;

endpackage

/* hw/smpc_rtc.sv */
`timescale 1ns/1ns
module smpc_rtc (
	input  logic            CLK,
	input  logic            RST_N,
	input  logic            time_load,
	input  smpc_pkg::byte_t ireg0,
	input  smpc_pkg::byte_t ireg1,
	input  smpc_pkg::byte_t ireg2,
	input  smpc_pkg::byte_t ireg3,
	input  smpc_pkg::byte_t ireg4,
	input  smpc_pkg::byte_t ireg5,
	input  smpc_pkg::byte_t ireg6,
	output smpc_pkg::byte_t year_hi,
	output smpc_pkg::byte_t year_lo,
	output smpc_pkg::byte_t month,
	output smpc_pkg::byte_t days,
	output smpc_pkg::byte_t hour,
	output smpc_pkg::byte_t min,
	output smpc_pkg::byte_t sec
);
	import smpc_pkg::*;

	logic [10:0] div_cnt;
	logic        tick;
	logic        min_clk;
	logic        hour_clk;
	logic        days_clk;
	logic        month_clk;
	logic        year_clk;
	logic        last_day;

	function automatic byte_t bcd_inc(input byte_t v);
		if (v[3:0] == 4'd9)
			return {v[7:4] + 4'd1, 4'd0};
		return {v[7:4], v[3:0] + 4'd1};
	endfunction

	assign tick = (div_cnt == 11'(RTC_TICK_CYCLES - 1));

	always_comb begin
		case (month[3:0])     // Month is a plain binary nibble, 1 to 12
			4'd2: last_day = (days == 8'h28);
			4'd4, 4'd6, 4'd9, 4'd11: last_day = (days == 8'h30);
			default: last_day = (days == 8'h31);
		endcase
	end

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			div_cnt <= '0;
			{min_clk, hour_clk, days_clk, month_clk, year_clk} <= '0;
			sec     <= 8'h00;
			min     <= 8'h00;
			hour    <= 8'h00;
			days    <= 8'h01;
			month   <= 8'h01;
			year_hi <= 8'h20;
			year_lo <= 8'h24;
		end else if (time_load) begin
			div_cnt <= '0;
			{min_clk, hour_clk, days_clk, month_clk, year_clk} <= '0;
			sec     <= ireg6;
			min     <= ireg5;
			hour    <= ireg4;
			days    <= ireg3;
			month   <= ireg2;     // Day of week and month
			year_hi <= ireg0;
			year_lo <= ireg1;
		end else begin
			div_cnt <= tick ? 11'd0 : div_cnt + 11'd1;
			{min_clk, hour_clk, days_clk, month_clk, year_clk} <= '0;
			// Carry moves up one field per cycle
			if (tick) begin
				if (sec == 8'h59) begin
					sec     <= 8'h00;
					min_clk <= 1'b1;
				end else
					sec <= bcd_inc(sec);
			end
			if (min_clk) begin
				if (min == 8'h59) begin
					min      <= 8'h00;
					hour_clk <= 1'b1;
				end else
					min <= bcd_inc(min);
			end
			if (hour_clk) begin
				if (hour == 8'h23) begin
					hour     <= 8'h00;
					days_clk <= 1'b1;
				end else
					hour <= bcd_inc(hour);
			end
			if (days_clk) begin
				if (last_day) begin
					days      <= 8'h01;
					month_clk <= 1'b1;
				end else
					days <= bcd_inc(days);
			end
			if (month_clk) begin
				if (month[3:0] == 4'd12) begin
					month[3:0] <= 4'd1;
					year_clk   <= 1'b1;
				end else
					month[3:0] <= month[3:0] + 4'd1;
			end
			if (year_clk) begin
				if (year_lo == 8'h99) begin
					year_lo <= 8'h00;
					year_hi <= (year_hi == 8'h99) ? 8'h00 : bcd_inc(year_hi);
				end else
					year_lo <= bcd_inc(year_lo);
			end
		end
	end

endmodule

/* hw/smpc_top.sv */
`timescale 1ns/1ns
module smpc_top (
	input  logic            CLK,
	input  logic            RST_N,
	input  logic [6:1]      A,
	input  smpc_pkg::byte_t DI,
	output smpc_pkg::byte_t DO,
	input  logic            CS_N,
	input  logic            RW_N,
	output logic            SSHRES_N,
	output logic            SNDRES_N,
	output logic            CDRES_N,
	output logic            MIRQ_N
);
	import smpc_pkg::*;

	logic       cmd_valid;
	logic       sf_clear;
	logic       oreg_we;
	logic       time_load;
	byte_t      cmd_byte;
	byte_t      sr;
	byte_t      oreg_q;
	byte_t      oreg_wd;
	byte_t      ireg0, ireg1, ireg2, ireg3, ireg4, ireg5, ireg6;
	byte_t      year_hi, year_lo, month, days, hour, min, sec;
	oreg_addr_t oreg_raddr;
	oreg_addr_t oreg_wa;

	smpc_bus_regs smpc_bus_regs_inst (
		.*,
		.a       (A),
		.di      (DI),
		.cs_n    (CS_N),
		.rw_n    (RW_N),
		.do_data (DO)
	);

	smpc_cmd_seq smpc_cmd_seq_inst (.*);

	smpc_rtc smpc_rtc_inst (.*);

	smpc_oreg_ram smpc_oreg_ram_inst (
		.CLK (CLK),
		.we  (oreg_we),
		.wa  (oreg_wa),
		.wd  (oreg_wd),
		.ra  (oreg_raddr),
		.q   (oreg_q)
	);

endmodule

/* smpc.f */
hw/smpc_pkg.sv
hw/smpc_oreg_ram.sv
hw/smpc_rtc.sv
hw/smpc_bus_regs.sv
hw/smpc_cmd_seq.sv
hw/smpc_top.sv
verification/smpc_tb.sv

/* verification/smpc_tb.sv */
`timescale 1ns/1ns
module smpc_tb;
	import smpc_pkg::*;

	logic        CLK;
	logic        RST_N;
	logic [6:1]  A;
	byte_t       DI;
	byte_t       DO;
	logic        CS_N;
	logic        RW_N;
	logic        SSHRES_N;
	logic        SNDRES_N;
	logic        CDRES_N;
	logic        MIRQ_N;

	int          seed = 32'h7001_0e7a;
	int unsigned cycle_cnt = 0;
	int unsigned mirq_lows = 0;
	logic        exp_ssh;
	logic        exp_snd;
	logic        exp_cd;
	logic        exp_ste;
	logic        exp_resd;
	byte_t       rd;
	logic [55:0] set_cal;     // {year_hi, year_lo, month, days, hour, min, sec}
	byte_t       reset_cmds [6];

	smpc_top smpc_top_inst (.*);

	always #20 CLK = ~CLK;

	always @(posedge CLK)
		cycle_cnt <= cycle_cnt + 1;

	always @(negedge CLK)
		if (RST_N && !MIRQ_N)
			mirq_lows <= mirq_lows + 1;     // Low cycles of the host interrupt

	function automatic logic [5:0] bus_a(input reg_addr_t addr);
		return addr[6:1];
	endfunction

	function automatic int bcd_to_int(input byte_t v);
		return v[7:4] * 10 + v[3:0];
	endfunction

	function automatic byte_t int_to_bcd(input int v);
		return {4'(v / 10), 4'(v % 10)};
	endfunction

	function automatic int random_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic int month_days(input int mo);
		case (mo)
			2: return 28;
			4, 6, 9, 11: return 30;
			default: return 31;
		endcase
	endfunction

	// Calendar after the given number of seconds; month is a binary nibble
	function automatic logic [55:0] ref_calendar(input logic [55:0] cal, input int ticks);
		int yr;
		int wd;
		int mo;
		int dy;
		int hr;
		int mi;
		int se;
		int i;
		yr = bcd_to_int(cal[55:48]) * 100 + bcd_to_int(cal[47:40]);
		wd = cal[39:36];
		mo = cal[35:32];
		dy = bcd_to_int(cal[31:24]);
		hr = bcd_to_int(cal[23:16]);
		mi = bcd_to_int(cal[15:8]);
		se = bcd_to_int(cal[7:0]);
		for (i = 0; i < ticks; i++) begin
			se++;
			if (se == 60) begin
				se = 0;
				mi++;
			end
			if (mi == 60) begin
				mi = 0;
				hr++;
			end
			if (hr == 24) begin
				hr = 0;
				dy++;
			end
			if (dy > month_days(mo)) begin
				dy = 1;
				mo++;
			end
			if (mo == 13) begin
				mo = 1;
				yr = (yr + 1) % 10000;
			end
		end
		return {int_to_bcd(yr / 100), int_to_bcd(yr % 100), 4'(wd), 4'(mo),
			int_to_bcd(dy), int_to_bcd(hr), int_to_bcd(mi), int_to_bcd(se)};
	endfunction

	task automatic stop_with_failure();
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input byte_t act, input byte_t exp);
		if (act !== exp) begin
			$display("mismatch at %0t ns: %s = %h, expected %h", $time, name, act, exp);
			stop_with_failure();
		end
	endtask

	task automatic check_line(input string name, input logic act, input logic exp);
		if (act !== exp) begin
			$display("mismatch at %0t ns: %s = %b, expected %b", $time, name, act, exp);
			stop_with_failure();
		end
	endtask

	task automatic write_reg(input logic [5:0] addr6, input byte_t data);
		@(posedge CLK);
		A    <= addr6;
		DI   <= data;
		CS_N <= 1'b0;
		@(posedge CLK);
		RW_N <= 1'b0;     // Write strobe
		repeat (2) @(posedge CLK);
		RW_N <= 1'b1;
		CS_N <= 1'b1;
		@(posedge CLK);
	endtask

	task automatic read_reg(input logic [5:0] addr6, output byte_t data);
		@(posedge CLK);
		A    <= addr6;
		RW_N <= 1'b1;
		CS_N <= 1'b0;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		data = DO;
		@(posedge CLK);
		CS_N <= 1'b1;
		@(posedge CLK);
	endtask

	task automatic wait_sf_clear();
		int unsigned start;
		byte_t       sf_rd;
		start = cycle_cnt;
		read_reg(bus_a(ADDR_SF), sf_rd);
		while (sf_rd[0]) begin
			if (cycle_cnt - start > 1000) begin
				$display("timeout: SF still set 1000 cycles after the command");
				stop_with_failure();
			end
			read_reg(bus_a(ADDR_SF), sf_rd);
		end
	endtask

	task automatic run_command(input byte_t cmd);
		write_reg(bus_a(ADDR_SF), 8'h01);
		write_reg(bus_a(ADDR_COMREG), cmd);
		wait_sf_clear();
	endtask

	task automatic check_lines();
		@(negedge CLK);
		check_line("SSHRES_N", SSHRES_N, exp_ssh);
		check_line("SNDRES_N", SNDRES_N, exp_snd);
		check_line("CDRES_N", CDRES_N, exp_cd);
	endtask

	task automatic load_time(input logic [55:0] cal);
		int k;
		for (k = 0; k < 7; k++)
			write_reg(bus_a(ADDR_IREG0) + 6'(k), cal[55 - 8 * k -: 8]);
		run_command(CMD_SETTIME);
	endtask

	// INTBACK status, then OREG0, SR and the interrupt pulse
	task automatic run_intback(input byte_t exp_oreg0);
		int unsigned lows_before;
		byte_t       v;
		write_reg(bus_a(ADDR_IREG0), 8'h01);
		lows_before = mirq_lows;
		run_command(CMD_INTBACK);
		check_line("MIRQ_N single pulse", (mirq_lows - lows_before) == 1, 1'b1);
		read_reg(bus_a(ADDR_OREG_FIRST), v);
		check_byte("OREG0", v, exp_oreg0);
		read_reg(bus_a(ADDR_SR), v);
		check_byte("SR", v, SR_STATUS);
	endtask

	task automatic check_calendar(input logic [55:0] exp);
		int    n;
		byte_t v;
		for (n = 1; n < 8; n++) begin
			read_reg(bus_a(ADDR_OREG_FIRST) + 6'(n), v);
			check_byte($sformatf("OREG%0d", n), v, exp[63 - 8 * n -: 8]);
		end
	endtask

	initial begin
		CLK      = 1'b0;
		RST_N    = 1'b0;
		A        = '0;
		DI       = '0;
		CS_N     = 1'b1;
		RW_N     = 1'b1;
		exp_ssh  = 1'b0;
		exp_snd  = 1'b0;
		exp_cd   = 1'b1;
		exp_ste  = 1'b0;
		exp_resd = 1'b1;
		reset_cmds = '{CMD_SSHON, CMD_SNDON, CMD_CDOFF, CMD_SSHOFF, CMD_SNDOFF, CMD_CDON};
		repeat (2) @(posedge CLK);
		RST_N <= 1'b1;

		check_lines();
		check_line("MIRQ_N", MIRQ_N, 1'b1);
		read_reg(bus_a(ADDR_SF), rd);
		check_line("SF", rd[0], 1'b0);

		foreach (reset_cmds[i]) begin
			write_reg(bus_a(ADDR_IREG1), byte_t'(random_below(256)));     // Filler
			run_command(reset_cmds[i]);
			case (reset_cmds[i])
				CMD_SSHON:  exp_ssh = 1'b1;
				CMD_SSHOFF: exp_ssh = 1'b0;
				CMD_SNDON:  exp_snd = 1'b1;
				CMD_SNDOFF: exp_snd = 1'b0;
				CMD_CDON:   exp_cd  = 1'b1;
				default:    exp_cd  = 1'b0;
			endcase
			check_lines();
			read_reg(bus_a(ADDR_OREG_LAST), rd);
			check_byte("OREG31", rd, reset_cmds[i]);
		end

		run_command(8'h25);     // Unknown code, no effect
		check_lines();
		read_reg(bus_a(ADDR_OREG_LAST), rd);
		check_byte("OREG31", rd, CMD_CDON);

		set_cal[55:48] = int_to_bcd(random_below(100));
		set_cal[47:40] = int_to_bcd(random_below(100));
		set_cal[39:32] = {4'(random_below(7)), 4'(1 + random_below(12))};
		set_cal[31:24] = int_to_bcd(1 + random_below(28));
		set_cal[23:16] = int_to_bcd(random_below(24));
		set_cal[15:8]  = int_to_bcd(random_below(60));
		set_cal[7:0]   = int_to_bcd(random_below(60));
		load_time(set_cal);
		exp_ste = 1'b1;
		run_intback({exp_ste, exp_resd, 6'b000000});
		check_calendar(ref_calendar(set_cal, 0));

		set_cal = 56'h19_99_0C_31_23_59_59;
		load_time(set_cal);
		repeat (2500) @(posedge CLK);
		run_intback({exp_ste, exp_resd, 6'b000000});
		check_calendar(ref_calendar(set_cal, 1));

		run_command(CMD_RESENAB);
		exp_resd = 1'b0;
		run_intback({exp_ste, exp_resd, 6'b000000});
		run_command(CMD_RESDISA);
		exp_resd = 1'b1;
		run_intback({exp_ste, exp_resd, 6'b000000});

		$display(">>> PASS");
		$finish;
	end

endmodule
